//--- include/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH_
`define DCACHE_CONFIG_SVH_

// Cache geometry
`define DC_N_WAY        2   // Associativity
`define DC_IDX_LEN      3   // Set index bits
`define DC_TAG_LEN      8   // Tag bits
`define DC_OFF_LEN      2   // Word offset inside a line

// Data and LSQ
`define DC_WORD_LEN     32
`define DC_LSQ_ADDR_LEN 3   // LSQ slot bits

// Miss and victim buffers
`define DC_MSHR_ENTRIES 2
`define DC_WBB_ENTRIES  2

`endif

//--- hw/dcache_pkg.sv
`include "dcache_config.svh"

package dcache_pkg;

  localparam int unsigned N_WAY   = `DC_N_WAY;
  localparam int unsigned N_WORDS = 2**`DC_OFF_LEN;  // Words per line

  // Address fields, data word and LSQ slot
  typedef logic [`DC_TAG_LEN-1:0]      tag_t;
  typedef logic [`DC_IDX_LEN-1:0]      idx_t;
  typedef logic [`DC_OFF_LEN-1:0]      line_off_t;
  typedef logic [`DC_WORD_LEN-1:0]     word_t;
  typedef logic [`DC_LSQ_ADDR_LEN-1:0] lsq_addr_t;

  // Key of both buffers
  typedef struct packed {
    tag_t tag;
    idx_t idx;
  } line_addr_t;

  typedef logic [N_WORDS-1:0][`DC_WORD_LEN-1:0] dcache_line_t;
  typedef logic [N_WAY-1:0]                     way_vec_t;  // Hit and replacement vectors

  typedef enum logic [1:0] {
    d1_none,
    d1_load,
    d1_refill  // Line back from L2, routed through d0
  } d1_req_kind_e;

  typedef struct packed {
    logic         valid;
    d1_req_kind_e kind;
    tag_t         tag;
    idx_t         idx;
    line_off_t    offset;
    lsq_addr_t    lsq_addr;
    dcache_line_t line;  // Refill data only
  } d0_d1_req_t;

  // Whole indexed set as read by d0
  typedef struct packed {
    tag_t [N_WAY-1:0]         tag_vec;
    way_vec_t                 valid_vec;
    way_vec_t                 dirty_vec;
    dcache_line_t [N_WAY-1:0] line_vec;
  } set_readout_t;

  typedef struct packed {
    logic      valid;
    logic      hit;
    word_t     data;
    lsq_addr_t lsq_addr;
  } lsq_ans_t;

  // Line write toward d0, the written line is clean
  typedef struct packed {
    logic         valid;
    idx_t         idx;
    way_vec_t     way_vec;
    dcache_line_t line;
  } d1_d0_write_t;

  // First load that missed on the line
  typedef struct packed {
    lsq_addr_t lsq_addr;
    line_off_t offset;
  } mshr_payload_t;

endpackage

//--- hw/l2_req_pkg.sv
package l2_req_pkg;

  import dcache_pkg::*;

  typedef enum logic {
    l2_fetch,       // Line read for an MSHR miss
    l2_write_back   // Dirty victim out of the WBB
  } l2_req_kind_e;

  typedef struct packed {
    logic         valid;
    l2_req_kind_e kind;
    line_addr_t   line_addr;
    dcache_line_t line;  // Meaningful on write-back only
  } l2_req_t;

  // Victim line held in the WBB
  typedef struct packed {
    dcache_line_t line;
  } wbb_payload_t;

endpackage

//--- hw/d1_tag_compare.sv
`timescale 1ns/100ps

module d1_tag_compare
  import dcache_pkg::*;
(
  input  tag_t         tag_i,
  input  idx_t         idx_i,               // Set of the request, for the victim address
  input  line_off_t    offset_i,
  input  set_readout_t set_readout_i,
  input  way_vec_t     victim_vec_i,        // One-hot way from the FIFO
  output way_vec_t     hit_vec_o,
  output logic         hit_o,
  output word_t        hit_word_o,
  output logic         victim_dirty_o,
  output line_addr_t   victim_line_addr_o,
  output dcache_line_t victim_line_o
);

  dcache_line_t hit_line;  // Line of the way that hit

  always_comb begin
    hit_line               = '0;
    victim_dirty_o         = 1'b0;
    victim_line_o          = '0;
    victim_line_addr_o.tag = '0;
    victim_line_addr_o.idx = idx_i;  // Same set as the request
    for (int w = 0; w < N_WAY; w++) begin
      // Only valid ways can hit
      hit_vec_o[w] = set_readout_i.valid_vec[w] && (set_readout_i.tag_vec[w] == tag_i);
      if (hit_vec_o[w]) hit_line = set_readout_i.line_vec[w];
      if (victim_vec_i[w]) begin
        // Write back only what is both valid and modified
        victim_dirty_o         = set_readout_i.valid_vec[w] && set_readout_i.dirty_vec[w];
        victim_line_addr_o.tag = set_readout_i.tag_vec[w];  // Stored tag rebuilds the address
        victim_line_o          = set_readout_i.line_vec[w];
      end
    end
  end

  assign hit_o      = |hit_vec_o;
  assign hit_word_o = hit_line[offset_i];  // Addressed word of the hit line

endmodule

//--- hw/d1_repl_fifo.sv
`timescale 1ns/100ps

module d1_repl_fifo
  import dcache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  idx_t     idx_i,
  input  logic     advance_i,      // Refill written into the pointed way
  output way_vec_t victim_vec_o
);

  localparam int unsigned N_SETS = 2**$bits(idx_t);
  localparam int unsigned PTR_W  = (N_WAY > 1) ? $clog2(N_WAY) : 1;

  // Next way to replace, one per set
  logic [PTR_W-1:0] ptr_q [N_SETS];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < N_SETS; s++) begin
        ptr_q[s] <= '0;  // Way 0 first
      end
    end else if (advance_i) begin
      // Round robin over the ways of this set
      if (ptr_q[idx_i] == PTR_W'(N_WAY - 1)) ptr_q[idx_i] <= '0;
      else ptr_q[idx_i] <= ptr_q[idx_i] + 1'b1;
    end
  end

  assign victim_vec_o = way_vec_t'(1) << ptr_q[idx_i];  // One-hot victim

endmodule

//--- hw/d1_entry_buffer.sv
`timescale 1ns/100ps

module d1_entry_buffer
  import dcache_pkg::*;
#(
  parameter int unsigned N_ENTRIES = 2,
  parameter type         payload_t = logic
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       add_i,
  input  line_addr_t add_key_i,
  input  payload_t   add_payload_i,
  input  line_addr_t lookup_key_i,
  input  logic       clr_hit_i,        // Free the entry that matched the lookup
  output logic       hit_o,
  output payload_t   hit_payload_o,
  output logic       full_o,
  output logic       req_valid_o,      // Issue side toward L2
  output line_addr_t req_key_o,
  output payload_t   req_payload_o,
  input  logic       req_accept_i,
  input  logic       free_on_accept_i  // 1 for WBB, 0 for MSHR
);

  localparam int unsigned IDX_W = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;

  typedef enum logic [1:0] {
    ent_free,
    ent_pending,  // Waiting to go to L2
    ent_sent      // Fetch issued, waiting for the refill
  } ent_state_e;

  ent_state_e       state_q   [N_ENTRIES];
  line_addr_t       key_q     [N_ENTRIES];
  payload_t         payload_q [N_ENTRIES];
  logic [IDX_W-1:0] hit_idx, free_idx, pend_idx, issue_idx;
  logic             any_free, any_pend;
  logic             hold_q;      // Offered last cycle and not taken
  logic [IDX_W-1:0] hold_idx_q;

  // Scan downward so the lowest index wins
  always_comb begin
    hit_o    = 1'b0;
    hit_idx  = '0;
    any_free = 1'b0;
    free_idx = '0;
    any_pend = 1'b0;
    pend_idx = '0;
    for (int i = N_ENTRIES - 1; i >= 0; i--) begin
      if (state_q[i] != ent_free && key_q[i] == lookup_key_i) begin
        hit_o   = 1'b1;
        hit_idx = IDX_W'(i);
      end
      if (state_q[i] == ent_free) begin
        any_free = 1'b1;
        free_idx = IDX_W'(i);
      end
      if (state_q[i] == ent_pending) begin
        any_pend = 1'b1;
        pend_idx = IDX_W'(i);
      end
    end
  end

  // Keep offering the same entry until L2 takes it
  assign issue_idx = (hold_q && state_q[hold_idx_q] == ent_pending) ? hold_idx_q : pend_idx;

  assign full_o        = !any_free;
  assign hit_payload_o = payload_q[hit_idx];
  assign req_valid_o   = any_pend;
  assign req_key_o     = key_q[issue_idx];
  assign req_payload_o = payload_q[issue_idx];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < N_ENTRIES; i++) begin
        state_q[i] <= ent_free;
      end
      hold_q     <= 1'b0;
      hold_idx_q <= '0;
    end else begin
      if (add_i && any_free) state_q[free_idx] <= ent_pending;
      if (req_accept_i) state_q[issue_idx] <= free_on_accept_i ? ent_free : ent_sent;
      if (clr_hit_i && hit_o) state_q[hit_idx] <= ent_free;  // Refill done
      hold_q     <= req_valid_o && !req_accept_i;
      hold_idx_q <= issue_idx;
    end
  end

  // Entry contents
  always_ff @(posedge clk_i) begin
    if (add_i && any_free) begin
      key_q[free_idx]     <= add_key_i;
      payload_q[free_idx] <= add_payload_i;
    end
  end

endmodule

//--- hw/d1_l2_arbiter.sv
`timescale 1ns/100ps

module d1_l2_arbiter
  import dcache_pkg::*, l2_req_pkg::*;
(
  input  logic         mshr_req_valid_i,
  input  line_addr_t   mshr_req_key_i,
  input  logic         wbb_req_valid_i,
  input  line_addr_t   wbb_req_key_i,
  input  wbb_payload_t wbb_req_payload_i,
  input  logic         l2_req_rdy_i,
  input  logic         wbb_full_i,      // Gives the WBB priority
  output l2_req_t      l2_req_o,
  output logic         mshr_accept_o,
  output logic         wbb_accept_o
);

  logic wbb_wins;

  // Drain a full WBB first, else fetches go ahead
  assign wbb_wins = wbb_req_valid_i && (wbb_full_i || !mshr_req_valid_i);

  always_comb begin
    l2_req_o.valid = mshr_req_valid_i || wbb_req_valid_i;
    if (wbb_wins) begin
      l2_req_o.kind      = l2_write_back;
      l2_req_o.line_addr = wbb_req_key_i;
      l2_req_o.line      = wbb_req_payload_i.line;
    end else begin
      l2_req_o.kind      = l2_fetch;
      l2_req_o.line_addr = mshr_req_key_i;
      l2_req_o.line      = '0;  // No data on a fetch
    end
  end

  // One-cycle accept to the winner only
  assign wbb_accept_o  = wbb_wins && l2_req_rdy_i;
  assign mshr_accept_o = !wbb_wins && mshr_req_valid_i && l2_req_rdy_i;

endmodule

//--- hw/d1_ctrl.sv
`timescale 1ns/100ps

module d1_ctrl
  import dcache_pkg::*;
(
  input  d0_d1_req_t    req_i,
  input  logic          hit_i,
  input  word_t         hit_word_i,
  input  logic          victim_dirty_i,
  input  way_vec_t      victim_vec_i,
  input  logic          mshr_hit_i,
  input  mshr_payload_t mshr_hit_payload_i,
  input  logic          mshr_full_i,
  input  logic          wbb_hit_i,
  input  logic          wbb_full_i,
  output logic          rdy_o,
  output lsq_ans_t      lsq_ans_o,
  output d1_d0_write_t  d0_write_o,
  output logic          mshr_add_o,
  output logic          mshr_clr_o,
  output logic          wbb_add_o,
  output logic          repl_advance_o
);

  always_comb begin
    rdy_o          = 1'b1;
    lsq_ans_o      = '0;
    d0_write_o     = '0;
    mshr_add_o     = 1'b0;
    mshr_clr_o     = 1'b0;
    wbb_add_o      = 1'b0;
    repl_advance_o = 1'b0;
    if (req_i.valid) begin
      case (req_i.kind)
        d1_load: begin
          lsq_ans_o.lsq_addr = req_i.lsq_addr;
          lsq_ans_o.data     = hit_word_i;
          if (hit_i) begin
            lsq_ans_o.valid = 1'b1;
            lsq_ans_o.hit   = 1'b1;
          end else if (wbb_hit_i || (!mshr_hit_i && mshr_full_i)) begin
            rdy_o = 1'b0;  // Line leaving or no room, d0 holds the load
          end else begin
            lsq_ans_o.valid = 1'b1;          // Miss, LSQ retries later
            mshr_add_o      = !mshr_hit_i;   // Fetch the line once
          end
        end
        d1_refill: begin
          if (victim_dirty_i && wbb_full_i) begin
            rdy_o = 1'b0;  // Nowhere to put the dirty victim
          end else begin
            d0_write_o.valid   = 1'b1;
            d0_write_o.idx     = req_i.idx;
            d0_write_o.way_vec = victim_vec_i;
            d0_write_o.line    = req_i.line;
            wbb_add_o          = victim_dirty_i;
            repl_advance_o     = 1'b1;
            mshr_clr_o         = mshr_hit_i;
            // Wake the load that first missed
            lsq_ans_o.valid    = mshr_hit_i;
            lsq_ans_o.hit      = mshr_hit_i;
            lsq_ans_o.data     = req_i.line[mshr_hit_payload_i.offset];
            lsq_ans_o.lsq_addr = mshr_hit_payload_i.lsq_addr;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

//--- hw/dcache_d1.sv
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_d1
  import dcache_pkg::*, l2_req_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  d0_d1_req_t   d0_d1_req_i,    // Stage register from d0
  input  set_readout_t set_readout_i,
  output logic         d1_d0_rdy_o,
  output d1_d0_write_t d1_d0_write_o,  // Refill line write
  output lsq_ans_t     lsq_ans_o,
  output l2_req_t      l2_req_o,
  input  logic         l2_req_rdy_i
);

  line_addr_t    req_line_addr;
  way_vec_t      victim_vec;
  logic          hit, victim_dirty;
  word_t         hit_word;
  line_addr_t    victim_line_addr;
  dcache_line_t  victim_line;
  logic          repl_advance;
  // MSHR side
  logic          mshr_add, mshr_clr, mshr_hit, mshr_full;
  logic          mshr_req_valid, mshr_accept;
  mshr_payload_t mshr_add_payload, mshr_hit_payload;
  line_addr_t    mshr_req_key;
  // WBB side
  logic          wbb_add, wbb_hit, wbb_full;
  logic          wbb_req_valid, wbb_accept;
  wbb_payload_t  wbb_add_payload, wbb_req_payload;
  line_addr_t    wbb_req_key;
  // L2 port
  logic          l2_hold_q, l2_hold_wb_q, wbb_prio;

  assign req_line_addr.tag = d0_d1_req_i.tag;
  assign req_line_addr.idx = d0_d1_req_i.idx;

  d1_tag_compare u_tag_compare (
    .tag_i(d0_d1_req_i.tag), .idx_i(d0_d1_req_i.idx), .offset_i(d0_d1_req_i.offset),
    .set_readout_i(set_readout_i), .victim_vec_i(victim_vec),
    .hit_vec_o(), .hit_o(hit), .hit_word_o(hit_word), .victim_dirty_o(victim_dirty),
    .victim_line_addr_o(victim_line_addr), .victim_line_o(victim_line)
  );

  d1_repl_fifo u_repl_fifo (
    .clk_i(clk_i), .rst_ni(rst_ni), .idx_i(d0_d1_req_i.idx),
    .advance_i(repl_advance), .victim_vec_o(victim_vec)
  );

  d1_ctrl u_ctrl (
    .req_i(d0_d1_req_i), .hit_i(hit), .hit_word_i(hit_word),
    .victim_dirty_i(victim_dirty), .victim_vec_i(victim_vec),
    .mshr_hit_i(mshr_hit), .mshr_hit_payload_i(mshr_hit_payload), .mshr_full_i(mshr_full),
    .wbb_hit_i(wbb_hit), .wbb_full_i(wbb_full),
    .rdy_o(d1_d0_rdy_o), .lsq_ans_o(lsq_ans_o), .d0_write_o(d1_d0_write_o),
    .mshr_add_o(mshr_add), .mshr_clr_o(mshr_clr), .wbb_add_o(wbb_add),
    .repl_advance_o(repl_advance)
  );

  assign mshr_add_payload.lsq_addr = d0_d1_req_i.lsq_addr;
  assign mshr_add_payload.offset   = d0_d1_req_i.offset;
  assign wbb_add_payload.line      = victim_line;

  d1_entry_buffer #(.N_ENTRIES(`DC_MSHR_ENTRIES), .payload_t(mshr_payload_t)) u_mshr (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .add_i(mshr_add), .add_key_i(req_line_addr), .add_payload_i(mshr_add_payload),
    .lookup_key_i(req_line_addr), .clr_hit_i(mshr_clr),
    .hit_o(mshr_hit), .hit_payload_o(mshr_hit_payload), .full_o(mshr_full),
    .req_valid_o(mshr_req_valid), .req_key_o(mshr_req_key), .req_payload_o(),
    .req_accept_i(mshr_accept), .free_on_accept_i(1'b0)  // Held until the refill
  );

  d1_entry_buffer #(.N_ENTRIES(`DC_WBB_ENTRIES), .payload_t(wbb_payload_t)) u_wbb (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .add_i(wbb_add), .add_key_i(victim_line_addr), .add_payload_i(wbb_add_payload),
    .lookup_key_i(req_line_addr), .clr_hit_i(1'b0),
    .hit_o(wbb_hit), .hit_payload_o(), .full_o(wbb_full),
    .req_valid_o(wbb_req_valid), .req_key_o(wbb_req_key), .req_payload_o(wbb_req_payload),
    .req_accept_i(wbb_accept), .free_on_accept_i(1'b1)   // Gone once L2 takes it
  );

  // A stalled L2 request keeps its winner so the port stays stable
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      l2_hold_q    <= 1'b0;
      l2_hold_wb_q <= 1'b0;
    end else begin
      l2_hold_q    <= l2_req_o.valid && !l2_req_rdy_i;
      l2_hold_wb_q <= (l2_req_o.kind == l2_write_back);
    end
  end

  assign wbb_prio = l2_hold_q ? l2_hold_wb_q : wbb_full;

  d1_l2_arbiter u_l2_arbiter (
    .mshr_req_valid_i(mshr_req_valid), .mshr_req_key_i(mshr_req_key),
    .wbb_req_valid_i(wbb_req_valid), .wbb_req_key_i(wbb_req_key),
    .wbb_req_payload_i(wbb_req_payload),
    .l2_req_rdy_i(l2_req_rdy_i), .wbb_full_i(wbb_prio),
    .l2_req_o(l2_req_o), .mshr_accept_o(mshr_accept), .wbb_accept_o(wbb_accept)
  );

endmodule

//--- verif/dcache_d1_properties.sv
`timescale 1ns/100ps

module dcache_d1_properties
  import dcache_pkg::*, l2_req_pkg::*;
(
  input logic         clk_i,
  input logic         rst_ni,
  input logic         d1_d0_rdy_i,
  input d1_d0_write_t d1_d0_write_i,
  input lsq_ans_t     lsq_ans_i,
  input l2_req_t      l2_req_i,
  input logic         l2_req_rdy_i
);

  // Request held unchanged until L2 takes it
  l2_req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (l2_req_i.valid && !l2_req_rdy_i) |=> (l2_req_i.valid && $stable(l2_req_i)))
    else $error("L2 request changed while waiting for ready");

  // A refill that is refused must not write the line
  write_when_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(d1_d0_write_i.valid && !d1_d0_rdy_i))
    else $error("Line write issued while d1 is not ready");

  answer_hit_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(!lsq_ans_i.valid && lsq_ans_i.hit))
    else $error("LSQ answer flags a hit without valid");

endmodule

bind dcache_d1 dcache_d1_properties u_properties (
  .clk_i(clk_i), .rst_ni(rst_ni), .d1_d0_rdy_i(d1_d0_rdy_o), .d1_d0_write_i(d1_d0_write_o),
  .lsq_ans_i(lsq_ans_o), .l2_req_i(l2_req_o), .l2_req_rdy_i(l2_req_rdy_i)
);

//--- verif/tb_dcache_d1.sv
`timescale 1ns/100ps
`include "dcache_config.svh"

module tb_dcache_d1
  import dcache_pkg::*, l2_req_pkg::*;
();

  localparam int N_SETS      = 2**`DC_IDX_LEN;
  localparam int N_ROWS      = 24;
  localparam int CYCLE_LIMIT = 40 * N_ROWS + 200;
  localparam int CW          = $bits(dcache_line_t);  // Widest compared value

  // Refill rows carry the slot and offset of the load they should wake
  typedef struct packed {
    logic      refill;
    tag_t      tag;
    idx_t      idx;
    line_off_t off;
    lsq_addr_t lsq;
    logic      sync;       // Let L2 drain first
    logic      stall;      // L2 ready forced low from this row on
    logic      rdy;
    logic      ans_valid;
    logic      ans_hit;
    logic      fetch;      // New Fetch expected
  } row_t;

  localparam row_t ROWS [N_ROWS] = '{
    // rf   tag    idx   off   lsq   sync  stall rdy   av    ah    fetch
    '{1'b0, 8'h20, 3'd2, 2'd1, 3'd1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0},  // Clean hit
    '{1'b0, 8'h11, 3'd1, 2'd3, 3'd2, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0},  // Dirty hit, way 1
    '{1'b0, 8'h30, 3'd3, 2'd2, 3'd2, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1},
    '{1'b0, 8'h30, 3'd3, 2'd0, 3'd3, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0},  // Same line, no Fetch
    '{1'b0, 8'h40, 3'd4, 2'd1, 3'd4, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1},  // MSHR full after
    '{1'b0, 8'h50, 3'd5, 2'd3, 3'd5, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
    '{1'b1, 8'h30, 3'd3, 2'd2, 3'd2, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0},
    '{1'b0, 8'h50, 3'd5, 2'd3, 3'd5, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1},  // Room again
    '{1'b1, 8'h40, 3'd4, 2'd1, 3'd4, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0},
    '{1'b1, 8'h50, 3'd5, 2'd3, 3'd5, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0},
    '{1'b0, 8'h31, 3'd3, 2'd1, 3'd6, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1},
    '{1'b1, 8'h31, 3'd3, 2'd1, 3'd6, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0},  // Into way 1
    '{1'b0, 8'h32, 3'd3, 2'd0, 3'd7, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1},
    '{1'b1, 8'h32, 3'd3, 2'd0, 3'd7, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0},  // Wraps to way 0
    '{1'b0, 8'h31, 3'd3, 2'd2, 3'd1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0},
    '{1'b1, 8'h61, 3'd1, 2'd0, 3'd0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0},  // Evicts dirty 0x10
    '{1'b1, 8'h62, 3'd1, 2'd0, 3'd0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0},  // WBB full after
    '{1'b0, 8'h10, 3'd1, 2'd0, 3'd0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0},  // Line in WBB
    '{1'b0, 8'h70, 3'd6, 2'd3, 3'd7, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1},
    '{1'b1, 8'h06, 3'd0, 2'd0, 3'd0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0},  // No room for victim
    '{1'b0, 8'h10, 3'd1, 2'd0, 3'd0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1},  // WriteBack gone
    '{1'b1, 8'h70, 3'd6, 2'd3, 3'd7, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0},
    '{1'b1, 8'h10, 3'd1, 2'd0, 3'd0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0},  // Clean victim
    '{1'b1, 8'h06, 3'd0, 2'd2, 3'd0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0}   // Dirty 0x05 out
  };

  logic         clk_i, rst_ni;
  d0_d1_req_t   d0_req;
  set_readout_t readout;
  logic         d1_rdy, l2_rdy;
  d1_d0_write_t d0_write;
  lsq_ans_t     lsq_ans;
  l2_req_t      l2_req;
  // Set contents and FIFO pointers as d0 would hold them
  tag_t         mdl_tag   [N_SETS][N_WAY];
  logic         mdl_valid [N_SETS][N_WAY];
  logic         mdl_dirty [N_SETS][N_WAY];
  dcache_line_t mdl_line  [N_SETS][N_WAY];
  int           mdl_ptr   [N_SETS];
  l2_req_t      fetch_q [$];  // Expected, in issue order
  l2_req_t      wb_q [$];
  int           n_checks, n_errors, cycles, wb_pend;
  logic [31:0]  rng_state;
  logic         l2_stall, offer_held, full_at_offer;

  dcache_d1 u_dut (
    .clk_i(clk_i), .rst_ni(rst_ni), .d0_d1_req_i(d0_req), .set_readout_i(readout),
    .d1_d0_rdy_o(d1_rdy), .d1_d0_write_o(d0_write), .lsq_ans_o(lsq_ans),
    .l2_req_o(l2_req), .l2_req_rdy_i(l2_rdy)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;  // 8 ns period
  end

  // Memory word as a function of the whole address
  function automatic word_t word_pattern(tag_t tag, idx_t idx, int off);
    return {tag, 5'(idx), 3'(off), 8'h5a, ~tag};
  endfunction

  function automatic dcache_line_t line_pattern(tag_t tag, idx_t idx);
    dcache_line_t line;
    for (int w = 0; w < N_WORDS; w++) begin
      line[w] = word_pattern(tag, idx, w);
    end
    return line;
  endfunction

  function automatic logic [31:0] next_random(logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic set_readout_t build_readout(idx_t idx);
    set_readout_t ro;
    for (int w = 0; w < N_WAY; w++) begin
      ro.tag_vec[w]   = mdl_tag[idx][w];
      ro.valid_vec[w] = mdl_valid[idx][w];
      ro.dirty_vec[w] = mdl_dirty[idx][w];
      ro.line_vec[w]  = mdl_line[idx][w];
    end
    return ro;
  endfunction

  // Word a load hit should return, from the model
  function automatic word_t model_word(tag_t tag, idx_t idx, line_off_t off);
    word_t data;
    data = '0;
    for (int w = 0; w < N_WAY; w++) begin
      if (mdl_valid[idx][w] && mdl_tag[idx][w] == tag) data = mdl_line[idx][w][off];
    end
    return data;
  endfunction

  function automatic logic l2_idle();
    return fetch_q.size() == 0 && wb_q.size() == 0;
  endfunction

  // Preload a way, modified lines get data that differs from memory
  task automatic place_way(idx_t idx, int way, tag_t tag, logic dirty);
    mdl_valid[idx][way] = 1'b1;
    mdl_dirty[idx][way] = dirty;
    mdl_tag[idx][way]   = tag;
    mdl_line[idx][way]  = dirty ? ~line_pattern(tag, idx) : line_pattern(tag, idx);
  endtask

  task automatic compare_value(string name, logic [CW-1:0] exp, logic [CW-1:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("ERR %s: expected %h, got %h", name, exp, act);
    end
  endtask

  // One L2 acceptance against the expected queues
  task automatic record_accept();
    l2_req_t exp;
    if (l2_req.kind == l2_fetch) begin
      if (full_at_offer) begin
        n_errors++;
        $display("A Fetch was offered to L2 while the write-back buffer was full");
      end
      if (fetch_q.size() == 0) begin
        n_errors++;
        $display("L2 accepted a Fetch that was not expected");
      end else begin
        exp = fetch_q.pop_front();
        compare_value("fetch address", exp.line_addr, l2_req.line_addr);
      end
    end else begin
      wb_pend--;  // Entry leaves the WBB at this edge
      if (wb_q.size() == 0) begin
        n_errors++;
        $display("L2 accepted a WriteBack that was not expected");
      end else begin
        exp = wb_q.pop_front();
        compare_value("write-back address", exp.line_addr, l2_req.line_addr);
        compare_value("write-back line", exp.line, l2_req.line);
      end
    end
  endtask

  // Entered just after a rising edge
  task automatic apply_row(int r);
    row_t    row;
    int      way;
    string   p;
    l2_req_t exp_req;
    logic    wr;
    row      = ROWS[r];
    p        = $sformatf("row %0d ", r);
    wr       = row.refill && row.rdy;
    l2_stall = row.stall;
    @(negedge clk_i);
    d0_req.valid = 1'b0;
    while (row.sync && !l2_idle()) @(negedge clk_i);
    way             = mdl_ptr[row.idx];  // Victim named by the FIFO
    d0_req.valid    = 1'b1;
    d0_req.kind     = row.refill ? d1_refill : d1_load;
    d0_req.tag      = row.tag;
    d0_req.idx      = row.idx;
    d0_req.offset   = row.off;
    d0_req.lsq_addr = row.lsq;
    d0_req.line     = row.refill ? line_pattern(row.tag, row.idx) : '0;
    readout         = build_readout(row.idx);
    #2;
    compare_value({p, "ready"}, row.rdy, d1_rdy);
    compare_value({p, "answer valid"}, row.ans_valid, lsq_ans.valid);
    compare_value({p, "answer hit"}, row.ans_hit, lsq_ans.hit);
    if (row.ans_valid) begin
      compare_value({p, "answer slot"}, row.lsq, lsq_ans.lsq_addr);
    end
    if (row.ans_valid && row.ans_hit) begin
      compare_value({p, "answer data"}, row.refill ? word_pattern(row.tag, row.idx, row.off)
                    : model_word(row.tag, row.idx, row.off), lsq_ans.data);
    end
    compare_value({p, "write valid"}, wr, d0_write.valid);
    if (wr) begin
      compare_value({p, "write index"}, row.idx, d0_write.idx);
      compare_value({p, "write way"}, way_vec_t'(1) << way, d0_write.way_vec);
      compare_value({p, "write line"}, line_pattern(row.tag, row.idx), d0_write.line);
    end
    @(posedge clk_i);
    exp_req       = '0;
    exp_req.valid = 1'b1;
    if (row.fetch) begin
      exp_req.kind      = l2_fetch;
      exp_req.line_addr = {row.tag, row.idx};
      fetch_q.push_back(exp_req);
    end
    if (wr) begin
      if (mdl_valid[row.idx][way] && mdl_dirty[row.idx][way]) begin
        exp_req.kind      = l2_write_back;
        exp_req.line_addr = {mdl_tag[row.idx][way], row.idx};
        exp_req.line      = mdl_line[row.idx][way];
        wb_q.push_back(exp_req);
        wb_pend++;
      end
      place_way(row.idx, way, row.tag, 1'b0);  // Refilled lines are clean
      mdl_ptr[row.idx] = (way + 1) % N_WAY;
    end
  endtask

  // L2 model, ready from the xorshift stream, acceptance sampled before the edge
  always begin
    @(negedge clk_i);
    rng_state = next_random(rng_state);
    l2_rdy    = !l2_stall && rng_state[3];
    #3;
    if (rst_ni && l2_req.valid) begin
      if (!offer_held) full_at_offer = (wb_pend == `DC_WBB_ENTRIES);  // New offer
      if (l2_rdy) record_accept();
      offer_held = !l2_rdy;
    end else begin
      offer_held = 1'b0;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles without finishing the table", CYCLE_LIMIT);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    rst_ni        = 1'b0;
    d0_req        = '0;
    readout       = '0;
    l2_rdy        = 1'b0;
    l2_stall      = 1'b0;
    offer_held    = 1'b0;
    full_at_offer = 1'b0;
    n_checks      = 0;
    n_errors      = 0;
    cycles        = 0;
    wb_pend       = 0;
    rng_state     = 32'he36543f7;
    for (int s = 0; s < N_SETS; s++) begin
      mdl_ptr[s] = 0;
      for (int w = 0; w < N_WAY; w++) begin
        mdl_valid[s][w] = 1'b0;
        mdl_dirty[s][w] = 1'b0;
        mdl_tag[s][w]   = '0;
        mdl_line[s][w]  = '0;
      end
    end
    place_way(3'd1, 0, 8'h10, 1'b1);  // Set 1 fully dirty
    place_way(3'd1, 1, 8'h11, 1'b1);
    place_way(3'd2, 0, 8'h20, 1'b0);
    place_way(3'd0, 0, 8'h05, 1'b1);
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #2;
    compare_value("reset ready", 1'b1, d1_rdy);
    compare_value("reset L2 valid", 1'b0, l2_req.valid);
    compare_value("reset answer valid", 1'b0, lsq_ans.valid);
    compare_value("reset write valid", 1'b0, d0_write.valid);
    @(posedge clk_i);
    for (int r = 0; r < N_ROWS; r++) begin
      apply_row(r);
    end
    @(negedge clk_i);
    d0_req.valid = 1'b0;
    l2_stall     = 1'b0;
    while (!l2_idle()) @(negedge clk_i);  // Every request must still be accepted
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- dcache_d1.f
+incdir+include
hw/dcache_pkg.sv
hw/l2_req_pkg.sv
hw/d1_tag_compare.sv
hw/d1_repl_fifo.sv
hw/d1_entry_buffer.sv
hw/d1_l2_arbiter.sv
hw/d1_ctrl.sv
hw/dcache_d1.sv
verif/dcache_d1_properties.sv
verif/tb_dcache_d1.sv

//--- Bender.yml
package:
  name: dcache_d1

sources:
  - include_dirs:
      - include
    files:
      - hw/dcache_pkg.sv
      - hw/l2_req_pkg.sv
      - hw/d1_tag_compare.sv
      - hw/d1_repl_fifo.sv
      - hw/d1_entry_buffer.sv
      - hw/d1_l2_arbiter.sv
      - hw/d1_ctrl.sv
      - hw/dcache_d1.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/dcache_d1_properties.sv
      - verif/tb_dcache_d1.sv
